/* hw/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  pipe_pkg::instr_t instruction,
    input  pipe_pkg::pc_t    pc,
    input  pipe_pkg::word_t  data_a,
    input  pipe_pkg::word_t  data_b,
    id_ex_if.source          id_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;
    logic [IMM_W-1:0]    imm;
    logic [SHAMT_W-1:0]  shamt;
    logic                zero_ext;

    assign opcode   = instruction[OPCODE_LSB +: OPCODE_W];
    assign funct    = instruction[FUNCT_W-1:0];
    assign imm      = instruction[IMM_W-1:0];
    assign shamt    = instruction[SHAMT_LSB +: SHAMT_W];
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

    assign id_out.pc        = pc;
    assign id_out.data_a    = data_a;
    assign id_out.data_b    = data_b;
    assign id_out.rs        = instruction[RS_LSB +: REG_W];
    assign id_out.rt        = instruction[RT_LSB +: REG_W];
    assign id_out.rd        = instruction[RD_LSB +: REG_W];
    assign id_out.shamt     = {{(WORD_W-SHAMT_W){1'b0}}, shamt};
    assign id_out.immediate = zero_ext ? {{(WORD_W-IMM_W){1'b0}}, imm}
                                       : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign id_out.alu_op    = (opcode == OP_RTYPE) ? funct : opcode;

    always_comb begin
        // anything not listed below leaves every control low
        id_out.mem_signed  = 1'b0;
        id_out.reg_write   = 1'b0;
        id_out.mem_to_reg  = 1'b0;
        id_out.mem_read    = 1'b0;
        id_out.mem_write   = 1'b0;
        id_out.branch      = 1'b0;
        id_out.alu_src     = 1'b0;
        id_out.reg_dest    = 1'b0;
        id_out.byte_en     = 1'b0;
        id_out.halfword_en = 1'b0;
        id_out.word_en     = 1'b0;
        id_out.hlt         = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                id_out.reg_dest  = 1'b1;
                id_out.reg_write = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                id_out.alu_src   = 1'b1;
                id_out.reg_write = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                id_out.alu_src    = 1'b1;
                id_out.reg_write  = 1'b1;
                id_out.mem_to_reg = 1'b1;
                id_out.mem_read   = 1'b1;
                id_out.mem_signed = (opcode == OP_LB) || (opcode == OP_LH);
            end
            OP_SB, OP_SH, OP_SW: begin
                id_out.alu_src   = 1'b1;
                id_out.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: id_out.branch = 1'b1;   // compares data_a with data_b
            OP_HALT:        id_out.hlt    = 1'b1;
            default: ;
        endcase
        // access size only matters for memory operations
        if (id_out.mem_read || id_out.mem_write) begin
            id_out.byte_en     = (opcode == OP_LB) || (opcode == OP_LBU) || (opcode == OP_SB);
            id_out.halfword_en = (opcode == OP_LH) || (opcode == OP_LHU) || (opcode == OP_SH);
            id_out.word_en     = (opcode == OP_LW) || (opcode == OP_SW);
        end
    end

endmodule

`default_nettype wire

/* hw/ex_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_if;
    import pipe_pkg::*;

    word_t     alu_result;
    word_t     store_data;
    reg_addr_t write_reg;
    logic      branch_taken;
    pc_t       branch_target;
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    logic      mem_signed;
    logic      byte_en;
    logic      halfword_en;
    logic      word_en;
    logic      hlt;

    modport source (output alu_result, store_data, write_reg, branch_taken, branch_target,
                     reg_write, mem_to_reg, mem_read, mem_write, mem_signed, byte_en,
                     halfword_en, word_en, hlt);
    modport sink (input alu_result, store_data, write_reg, branch_taken, branch_target,
                  reg_write, mem_to_reg, mem_read, mem_write, mem_signed, byte_en,
                  halfword_en, word_en, hlt);

endinterface

`default_nettype wire

/* hw/ex_mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  pipeline_enable,
    ex_mem_if.sink               res_in,
    output pipe_pkg::word_t      alu_result,
    output pipe_pkg::word_t      store_data,
    output pipe_pkg::reg_addr_t  write_reg,
    output logic                 branch_taken,
    output pipe_pkg::pc_t        branch_target,
    output logic                 reg_write,
    output logic                 mem_to_reg,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 mem_signed,
    output logic                 byte_en,
    output logic                 halfword_en,
    output logic                 word_en,
    output logic                 halted
);

    always_ff @(negedge i_clock) begin
        if (i_reset) begin
            alu_result    <= '0;
            store_data    <= '0;
            write_reg     <= '0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
            reg_write     <= 1'b0;
            mem_to_reg    <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_signed    <= 1'b0;
            byte_en       <= 1'b0;
            halfword_en   <= 1'b0;
            word_en       <= 1'b0;
            halted        <= 1'b0;
        end else if (pipeline_enable) begin
            alu_result    <= res_in.alu_result;
            store_data    <= res_in.store_data;
            write_reg     <= res_in.write_reg;
            branch_taken  <= res_in.branch_taken;
            branch_target <= res_in.branch_target;
            reg_write     <= res_in.reg_write;
            mem_to_reg    <= res_in.mem_to_reg;
            mem_read      <= res_in.mem_read;
            mem_write     <= res_in.mem_write;
            mem_signed    <= res_in.mem_signed;
            byte_en       <= res_in.byte_en;
            halfword_en   <= res_in.halfword_en;
            word_en       <= res_in.word_en;
            halted        <= halted | res_in.hlt;   // only reset clears it
        end
    end

    // no instruction both loads and stores
    rd_wr_excl_a: assert property (@(negedge i_clock) disable iff (i_reset)
        !(mem_read && mem_write));

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    id_ex_if.sink    ex_in,
    ex_mem_if.source res_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t              operand_b;
    word_t              alu_result;
    logic [SHAMT_W-1:0] shift_const;
    logic [SHAMT_W-1:0] shift_var;
    logic               operands_equal;

    assign operand_b   = ex_in.alu_src ? ex_in.immediate : ex_in.data_b;
    assign shift_const = ex_in.shamt[SHAMT_W-1:0];
    assign shift_var   = ex_in.data_a[SHAMT_W-1:0];   // variable shifts take rs bits 4:0

    always_comb begin
        alu_result = '0;
        if (ex_in.reg_dest) begin
            // for r-type alu_op holds the funct field
            case (ex_in.alu_op)
                FN_ADDU: alu_result = ex_in.data_a + operand_b;
                FN_SUBU: alu_result = ex_in.data_a - operand_b;
                FN_AND:  alu_result = ex_in.data_a & operand_b;
                FN_OR:   alu_result = ex_in.data_a | operand_b;
                FN_XOR:  alu_result = ex_in.data_a ^ operand_b;
                FN_NOR:  alu_result = ~(ex_in.data_a | operand_b);
                FN_SLT:  alu_result = word_t'($signed(ex_in.data_a) < $signed(operand_b));
                FN_SLTU: alu_result = word_t'(ex_in.data_a < operand_b);
                FN_SLL:  alu_result = ex_in.data_b << shift_const;
                FN_SRL:  alu_result = ex_in.data_b >> shift_const;
                FN_SRA:  alu_result = $unsigned($signed(ex_in.data_b) >>> shift_const);
                FN_SLLV: alu_result = ex_in.data_b << shift_var;
                FN_SRLV: alu_result = ex_in.data_b >> shift_var;
                FN_SRAV: alu_result = $unsigned($signed(ex_in.data_b) >>> shift_var);
                default: ;
            endcase
        end else begin
            case (ex_in.alu_op)
                OP_ADDIU, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW:
                    alu_result = ex_in.data_a + operand_b;
                OP_SLTI:  alu_result = word_t'($signed(ex_in.data_a) < $signed(operand_b));
                OP_SLTIU: alu_result = word_t'(ex_in.data_a < operand_b);
                OP_ANDI:  alu_result = ex_in.data_a & operand_b;
                OP_ORI:   alu_result = ex_in.data_a | operand_b;
                OP_XORI:  alu_result = ex_in.data_a ^ operand_b;
                OP_LUI:   alu_result = {operand_b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
                OP_BEQ, OP_BNE: alu_result = ex_in.data_a - operand_b;
                default: ;
            endcase
        end
    end

    assign operands_equal = (ex_in.data_a == ex_in.data_b);

    assign res_out.alu_result    = alu_result;
    assign res_out.store_data    = ex_in.data_b;
    assign res_out.write_reg     = ex_in.reg_dest ? ex_in.rd : ex_in.rt;
    assign res_out.branch_taken  = ex_in.branch &&
                                   ((ex_in.alu_op == OP_BNE) ? !operands_equal : operands_equal);
    assign res_out.branch_target = ex_in.pc + 32'd4 + (ex_in.immediate << 2);
    assign res_out.reg_write     = ex_in.reg_write;
    assign res_out.mem_to_reg    = ex_in.mem_to_reg;
    assign res_out.mem_read      = ex_in.mem_read;
    assign res_out.mem_write     = ex_in.mem_write;
    assign res_out.mem_signed    = ex_in.mem_signed;
    assign res_out.byte_en       = ex_in.byte_en;
    assign res_out.halfword_en   = ex_in.halfword_en;
    assign res_out.word_en       = ex_in.word_en;
    assign res_out.hlt           = ex_in.hlt;

endmodule

`default_nettype wire

/* hw/id_ex_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    import pipe_pkg::*;

    logic      mem_signed;
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    logic      alu_src;
    logic      reg_dest;
    logic      byte_en;
    logic      halfword_en;
    logic      word_en;
    logic      hlt;
    alu_op_t   alu_op;
    pc_t       pc;
    word_t     data_a;
    word_t     data_b;
    word_t     immediate;   // already extended to 32 bits
    word_t     shamt;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    modport source (output mem_signed, reg_write, mem_to_reg, mem_read, mem_write, branch,
                     alu_src, reg_dest, byte_en, halfword_en, word_en, hlt, alu_op, pc,
                     data_a, data_b, immediate, shamt, rs, rt, rd);
    modport sink (input mem_signed, reg_write, mem_to_reg, mem_read, mem_write, branch,
                  alu_src, reg_dest, byte_en, halfword_en, word_en, hlt, alu_op, pc,
                  data_a, data_b, immediate, shamt, rs, rt, rd);

endinterface

`default_nettype wire

/* hw/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire     i_clock,
    input  wire     i_reset,
    input  wire     pipeline_enable,
    id_ex_if.sink   id_in,
    id_ex_if.source ex_out
);

    always_ff @(negedge i_clock) begin
        if (i_reset) begin
            ex_out.mem_signed  <= 1'b0;
            ex_out.reg_write   <= 1'b0;
            ex_out.mem_to_reg  <= 1'b0;
            ex_out.mem_read    <= 1'b0;
            ex_out.mem_write   <= 1'b0;
            ex_out.branch      <= 1'b0;
            ex_out.alu_src     <= 1'b0;
            ex_out.reg_dest    <= 1'b0;
            ex_out.byte_en     <= 1'b0;
            ex_out.halfword_en <= 1'b0;
            ex_out.word_en     <= 1'b0;
            ex_out.hlt         <= 1'b0;
            ex_out.alu_op      <= '0;
            ex_out.pc          <= '0;
            ex_out.data_a      <= '0;
            ex_out.data_b      <= '0;
            ex_out.immediate   <= '0;
            ex_out.shamt       <= '0;
            ex_out.rs          <= '0;
            ex_out.rt          <= '0;
            ex_out.rd          <= '0;
        end else if (pipeline_enable) begin   // a low enable holds the stage
            ex_out.mem_signed  <= id_in.mem_signed;
            ex_out.reg_write   <= id_in.reg_write;
            ex_out.mem_to_reg  <= id_in.mem_to_reg;
            ex_out.mem_read    <= id_in.mem_read;
            ex_out.mem_write   <= id_in.mem_write;
            ex_out.branch      <= id_in.branch;
            ex_out.alu_src     <= id_in.alu_src;
            ex_out.reg_dest    <= id_in.reg_dest;
            ex_out.byte_en     <= id_in.byte_en;
            ex_out.halfword_en <= id_in.halfword_en;
            ex_out.word_en     <= id_in.word_en;
            ex_out.hlt         <= id_in.hlt;
            ex_out.alu_op      <= id_in.alu_op;
            ex_out.pc          <= id_in.pc;
            ex_out.data_a      <= id_in.data_a;
            ex_out.data_b      <= id_in.data_b;
            ex_out.immediate   <= id_in.immediate;
            ex_out.shamt       <= id_in.shamt;
            ex_out.rs          <= id_in.rs;
            ex_out.rt          <= id_in.rt;
            ex_out.rd          <= id_in.rd;
        end
    end

    // decode must never request two access sizes for one instruction
    size_onehot_a: assert property (@(negedge i_clock) disable iff (i_reset)
        $onehot0({ex_out.byte_en, ex_out.halfword_en, ex_out.word_en}));

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;
    localparam int INSTR_W  = 32;

    // lsb positions of the fields that do not start at bit 0
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;

    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;
    localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'b001001;
    localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_SLTIU = 6'b001011;
    localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI   = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_XORI  = 6'b001110;
    localparam logic [OPCODE_W-1:0] OP_LUI   = 6'b001111;
    localparam logic [OPCODE_W-1:0] OP_LB    = 6'b100000;
    localparam logic [OPCODE_W-1:0] OP_LH    = 6'b100001;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
    localparam logic [OPCODE_W-1:0] OP_LBU   = 6'b100100;
    localparam logic [OPCODE_W-1:0] OP_LHU   = 6'b100101;
    localparam logic [OPCODE_W-1:0] OP_SB    = 6'b101000;
    localparam logic [OPCODE_W-1:0] OP_SH    = 6'b101001;
    localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;
    localparam logic [OPCODE_W-1:0] OP_HALT  = 6'b111111;

    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

/* hw/pipe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core (
    input  wire                 i_clock,
    input  wire                 i_reset,
    input  wire                 pipeline_enable,
    input  pipe_pkg::instr_t    instruction,
    input  pipe_pkg::pc_t       pc,
    input  pipe_pkg::word_t     data_a,
    input  pipe_pkg::word_t     data_b,
    output pipe_pkg::word_t     alu_result,
    output pipe_pkg::word_t     store_data,
    output pipe_pkg::reg_addr_t write_reg,
    output logic                branch_taken,
    output pipe_pkg::pc_t       branch_target,
    output logic                reg_write,
    output logic                mem_to_reg,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_signed,
    output logic                byte_en,
    output logic                halfword_en,
    output logic                word_en,
    output logic                halted
);

    id_ex_if  id_bus ();   // decode to the id/ex register
    id_ex_if  ex_bus ();   // id/ex register to execute
    ex_mem_if res_bus ();

    decode_unit decode_unit_inst (
        .instruction (instruction),
        .pc          (pc),
        .data_a      (data_a),
        .data_b      (data_b),
        .id_out      (id_bus)
    );

    id_ex_reg id_ex_reg_inst (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .pipeline_enable (pipeline_enable),
        .id_in           (id_bus),
        .ex_out          (ex_bus)
    );

    execute_unit execute_unit_inst (
        .ex_in   (ex_bus),
        .res_out (res_bus)
    );

    ex_mem_reg ex_mem_reg_inst (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .pipeline_enable (pipeline_enable),
        .res_in          (res_bus),
        .alu_result      (alu_result),
        .store_data      (store_data),
        .write_reg       (write_reg),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .reg_write       (reg_write),
        .mem_to_reg      (mem_to_reg),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_signed      (mem_signed),
        .byte_en         (byte_en),
        .halfword_en     (halfword_en),
        .word_en         (word_en),
        .halted          (halted)
    );

endmodule

`default_nettype wire

/* hw/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int WORD_W   = 32;
    localparam int ALU_OP_W = 6;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W-1:0]   pc_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;   // funct for r-type, opcode otherwise

    // the instruction and register widths come from the isa
    typedef logic [isa_pkg::INSTR_W-1:0] instr_t;
    typedef logic [isa_pkg::REG_W-1:0]   reg_addr_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module pipe_core_tb &&
./obj_dir/Vpipe_core_tb | tee /dev/stderr | grep -x "Simulation passed" > /dev/null &&
echo "run ok" || { echo "run failed"; exit 1; }

/* verification/pipe_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RTYPE    = 200;
    localparam int NUM_ITYPE    = 200;
    localparam int NUM_MEM      = 120;
    localparam int NUM_BRANCH   = 80;
    localparam int NUM_MIXED    = 300;
    localparam int NUM_HALT     = 20;
    // one clock per driven instruction, stalled or not, plus two resets and the drain
    localparam int NUM_CYCLES = 2 * (RESET_CYCLES + 2) + NUM_RTYPE + NUM_ITYPE + NUM_MEM
                                + NUM_BRANCH + NUM_MIXED + 2 * NUM_HALT + 8;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 50) * CLK_PERIOD;

    localparam int KIND_RTYPE  = 0;
    localparam int KIND_ITYPE  = 1;
    localparam int KIND_MEM    = 2;
    localparam int KIND_BRANCH = 3;
    localparam int KIND_ANY    = 4;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t write_reg;
        logic      branch_taken;
        pc_t       branch_target;
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_read;
        logic      mem_write;
        logic      mem_signed;
        logic      byte_en;
        logic      halfword_en;
        logic      word_en;
        logic      hlt;
    } result_t;

    logic      clock = 1'b0;
    logic      reset;
    logic      pipeline_enable;
    instr_t    instruction;
    pc_t       pc;
    word_t     data_a;
    word_t     data_b;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t write_reg;
    logic      branch_taken;
    pc_t       branch_target;
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    logic      mem_signed;
    logic      byte_en;
    logic      halfword_en;
    logic      word_en;
    logic      halted;

    result_t     expected_q [2];   // [0] sits in ID/EX, [1] is on the outputs
    logic        exp_halted = 1'b0;
    logic        model_ready = 1'b0;
    logic [31:0] lcg_state = 32'hdc39;

    pipe_core pipe_core_inst (
        .i_clock         (clock),
        .i_reset         (reset),
        .pipeline_enable (pipeline_enable),
        .instruction     (instruction),
        .pc              (pc),
        .data_a          (data_a),
        .data_b          (data_b),
        .alu_result      (alu_result),
        .store_data      (store_data),
        .write_reg       (write_reg),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .reg_write       (reg_write),
        .mem_to_reg      (mem_to_reg),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_signed      (mem_signed),
        .byte_en         (byte_en),
        .halfword_en     (halfword_en),
        .word_en         (word_en),
        .halted          (halted)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t pick_operand();
        logic [31:0] r;
        r = next_random();
        // small signed values now and then so compares and shifts see edge cases
        return (r[2:0] == 3'b000) ? {{24{r[15]}}, r[15:8]} : next_random();
    endfunction

    function automatic logic [FUNCT_W-1:0] rtype_funct(input logic [31:0] r);
        case (r % 32'd14)
            0:       return FN_ADDU;
            1:       return FN_SUBU;
            2:       return FN_AND;
            3:       return FN_OR;
            4:       return FN_XOR;
            5:       return FN_NOR;
            6:       return FN_SLT;
            7:       return FN_SLTU;
            8:       return FN_SLL;
            9:       return FN_SRL;
            10:      return FN_SRA;
            11:      return FN_SLLV;
            12:      return FN_SRLV;
            default: return FN_SRAV;
        endcase
    endfunction

    function automatic logic [OPCODE_W-1:0] itype_opcode(input logic [31:0] r);
        case (r % 32'd7)
            0:       return OP_ADDIU;
            1:       return OP_SLTI;
            2:       return OP_SLTIU;
            3:       return OP_ANDI;
            4:       return OP_ORI;
            5:       return OP_XORI;
            default: return OP_LUI;
        endcase
    endfunction

    function automatic logic [OPCODE_W-1:0] mem_opcode(input logic [31:0] r);
        case (r[2:0])
            3'd0:    return OP_LB;
            3'd1:    return OP_LH;
            3'd2:    return OP_LW;
            3'd3:    return OP_LBU;
            3'd4:    return OP_LHU;
            3'd5:    return OP_SB;
            3'd6:    return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    function automatic instr_t make_instr(input int kind);
        logic [31:0] r;
        instr_t      instr;
        int          sel;
        r     = next_random();
        instr = next_random();   // random register fields, shamt and immediate
        sel   = (kind == KIND_ANY) ? int'(r[29:28]) : kind;
        case (sel)
            KIND_RTYPE: begin
                instr[31:26] = OP_RTYPE;
                instr[5:0]   = rtype_funct(r);
            end
            KIND_ITYPE: instr[31:26] = itype_opcode(r);
            KIND_MEM:   instr[31:26] = mem_opcode(r);
            default:    instr[31:26] = r[0] ? OP_BEQ : OP_BNE;
        endcase
        return instr;
    endfunction

    function automatic logic signed_less(input word_t x, input word_t y);
        // differing signs decide alone, otherwise unsigned order is the signed order
        return (x[31] != y[31]) ? x[31] : (x < y);
    endfunction

    function automatic word_t shift_right_arith(input word_t value, input logic [4:0] amount);
        return (value >> amount) | (value[31] ? ~(32'hffff_ffff >> amount) : 32'h0);
    endfunction

    function automatic result_t expected_result(input instr_t instr, input pc_t pc_in,
                                                input word_t a, input word_t b);
        result_t          res;
        logic [5:0]       op;
        logic [5:0]       fn;
        logic [4:0]       sh;
        word_t            imm_s;
        word_t            imm_z;
        word_t            imm;
        op    = instr[31:26];
        fn    = instr[5:0];
        sh    = instr[10:6];
        imm_s = {{16{instr[15]}}, instr[15:0]};
        imm_z = {16'h0000, instr[15:0]};
        imm   = (op inside {OP_ANDI, OP_ORI, OP_XORI}) ? imm_z : imm_s;
        res   = '0;
        res.store_data    = b;
        res.write_reg     = (op == OP_RTYPE) ? instr[15:11] : instr[20:16];
        res.branch_target = pc_in + 32'd4 + {imm[29:0], 2'b00};
        case (op)
            OP_RTYPE: begin
                res.reg_write = 1'b1;
                case (fn)
                    FN_ADDU: res.alu_result = a + b;
                    FN_SUBU: res.alu_result = a - b;
                    FN_AND:  res.alu_result = a & b;
                    FN_OR:   res.alu_result = a | b;
                    FN_XOR:  res.alu_result = a ^ b;
                    FN_NOR:  res.alu_result = ~(a | b);
                    FN_SLT:  res.alu_result = {31'b0, signed_less(a, b)};
                    FN_SLTU: res.alu_result = {31'b0, a < b};
                    FN_SLL:  res.alu_result = b << sh;
                    FN_SRL:  res.alu_result = b >> sh;
                    FN_SRA:  res.alu_result = shift_right_arith(b, sh);
                    FN_SLLV: res.alu_result = b << a[4:0];
                    FN_SRLV: res.alu_result = b >> a[4:0];
                    FN_SRAV: res.alu_result = shift_right_arith(b, a[4:0]);
                    default: res.alu_result = '0;
                endcase
            end
            OP_ADDIU: res.alu_result = a + imm_s;
            OP_SLTI:  res.alu_result = {31'b0, signed_less(a, imm_s)};
            OP_SLTIU: res.alu_result = {31'b0, a < imm_s};
            OP_ANDI:  res.alu_result = a & imm_z;
            OP_ORI:   res.alu_result = a | imm_z;
            OP_XORI:  res.alu_result = a ^ imm_z;
            OP_LUI:   res.alu_result = {instr[15:0], 16'h0000};
            OP_BEQ, OP_BNE: begin
                res.alu_result   = a - b;
                res.branch_taken = (op == OP_BEQ) == (a == b);
            end
            OP_HALT: res.hlt = 1'b1;
            default: ;
        endcase
        res.reg_write = res.reg_write || (op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                                      OP_ORI, OP_XORI, OP_LUI});
        // loads and stores form the address the same way
        if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW}) begin
            res.alu_result  = a + imm_s;
            res.mem_read    = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
            res.mem_write   = !res.mem_read;
            res.reg_write   = res.mem_read;
            res.mem_to_reg  = res.mem_read;
            res.mem_signed  = op inside {OP_LB, OP_LH};
            res.byte_en     = op inside {OP_LB, OP_LBU, OP_SB};
            res.halfword_en = op inside {OP_LH, OP_LHU, OP_SH};
            res.word_en     = op inside {OP_LW, OP_SW};
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // the scoreboard moves exactly when the DUT registers do
    always @(negedge clock) begin
        if (reset) begin
            expected_q[0]               = '0;
            expected_q[0].branch_target = 32'd4;   // a cleared ID/EX entry still forms pc + 4
            expected_q[1]               = '0;
            exp_halted                  = 1'b0;
            model_ready                 = 1'b1;
        end else if (pipeline_enable) begin
            exp_halted    = exp_halted | expected_q[0].hlt;
            expected_q[1] = expected_q[0];
            expected_q[0] = expected_result(instruction, pc, data_a, data_b);
        end
    end

    always @(posedge clock) begin
        if (model_ready) begin   // outputs settled at the last falling edge
            check_value("alu_result", alu_result, expected_q[1].alu_result);
            check_value("store_data", store_data, expected_q[1].store_data);
            check_value("write_reg", 32'(write_reg), 32'(expected_q[1].write_reg));
            check_value("branch_taken", 32'(branch_taken), 32'(expected_q[1].branch_taken));
            check_value("branch_target", branch_target, expected_q[1].branch_target);
            check_value("reg_write", 32'(reg_write), 32'(expected_q[1].reg_write));
            check_value("mem_to_reg", 32'(mem_to_reg), 32'(expected_q[1].mem_to_reg));
            check_value("mem_read", 32'(mem_read), 32'(expected_q[1].mem_read));
            check_value("mem_write", 32'(mem_write), 32'(expected_q[1].mem_write));
            check_value("mem_signed", 32'(mem_signed), 32'(expected_q[1].mem_signed));
            check_value("byte_en", 32'(byte_en), 32'(expected_q[1].byte_en));
            check_value("halfword_en", 32'(halfword_en), 32'(expected_q[1].halfword_en));
            check_value("word_en", 32'(word_en), 32'(expected_q[1].word_en));
            check_value("halted", 32'(halted), 32'(exp_halted));
        end
    end

    task automatic drive(input instr_t instr, input pc_t pc_val, input word_t a,
                         input word_t b, input logic en);
        @(posedge clock);
        instruction     <= instr;
        pc              <= pc_val;
        data_a          <= a;
        data_b          <= b;
        pipeline_enable <= en;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset           <= 1'b1;
        pipeline_enable <= 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_phase(input int kind, input int count, input bit with_stalls);
        logic [31:0] r;
        word_t       a;
        word_t       b;
        int          i;
        for (i = 0; i < count; i++) begin
            r = next_random();
            a = pick_operand();
            b = (r[3:2] == 2'b00) ? a : pick_operand();   // equal operands for beq and bne
            drive(make_instr(kind), next_random() & 32'hffff_fffc, a, b,
                  !with_stalls || (r[1:0] != 2'b00));
        end
    endtask

    initial begin
        logic [31:0] r;
        reset           = 1'b1;
        pipeline_enable = 1'b0;
        instruction     = '0;
        pc              = '0;
        data_a          = '0;
        data_b          = '0;
        apply_reset();
        run_phase(KIND_RTYPE, NUM_RTYPE, 1'b0);
        run_phase(KIND_ITYPE, NUM_ITYPE, 1'b0);
        run_phase(KIND_MEM, NUM_MEM, 1'b0);
        run_phase(KIND_BRANCH, NUM_BRANCH, 1'b0);
        run_phase(KIND_ANY, NUM_MIXED, 1'b1);
        r = next_random();
        drive({OP_HALT, r[25:0]}, 32'h0000_0100, pick_operand(), pick_operand(), 1'b1);
        run_phase(KIND_ANY, NUM_HALT, 1'b1);
        check_value("halted after halt", 32'(halted), 32'd1);
        apply_reset();
        run_phase(KIND_ANY, NUM_HALT, 1'b1);
        repeat (4) @(posedge clock);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/id_ex_if.sv
hw/ex_mem_if.sv
hw/decode_unit.sv
hw/id_ex_reg.sv
hw/execute_unit.sv
hw/ex_mem_reg.sv
hw/pipe_core.sv
verification/pipe_core_tb.sv
